// ==== hw/hc_settings.svh ====
`ifndef HC_SETTINGS_SVH
`define HC_SETTINGS_SVH

// Width of one host channel line
`define HC_DATA_W 64

// Entries in each line FIFO, power of two
`define HC_FIFO_DEPTH 8

// Width of the source mode line counter
`define HC_COUNT_W 31

// APB byte offsets of the register block
`define HC_REG_CTRL   32'h0000_0000
`define HC_REG_TEST   32'h0000_0004
`define HC_REG_STATUS 32'h0000_0008

`endif

// ==== hw/hc_pkg.sv ====
`include "hc_settings.svh"

package hc_pkg;

    // One line on the host channel
    typedef logic [`HC_DATA_W-1:0] t_hc_line;

    // Number of lines sent in source mode
    typedef logic [`HC_COUNT_W-1:0] t_hc_count;

    // Test node mode, also the encoding of a test request
    typedef enum logic [1:0]
    {
        NORMAL,
        SINK,
        SOURCE,
        LOOPBACK
    } t_hc_mode;

    // Test request, a mode of NORMAL means no request
    typedef struct packed
    {
        t_hc_mode  mode;
        t_hc_count count;
    } t_hc_test_req;

    // Register state seen by the test node
    typedef struct packed
    {
        logic         client_en;
        t_hc_test_req test_req;
    } t_hc_csr;

    // Debug word, sampled by the test node one cycle late
    typedef struct packed
    {
        logic     rx_rdy;
        logic     rx_enable;
        logic     tx_rdy;
        logic     tx_enable;
        t_hc_mode mode;
    } t_hc_dbg;

endpackage

// ==== hw/hc_csr_apb.sv ====
`timescale 1ns/1ps

`include "hc_settings.svh"

module hc_csr_apb
(
    input  logic           clk,
    input  logic           reset_n,

    // APB slave
    input  logic [31:0]    paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,

    // Debug word from the test node
    input  hc_pkg::t_hc_dbg dbg,

    // Register state to the test node
    output hc_pkg::t_hc_csr csr
);

    import hc_pkg::*;

    // Access phase of a transfer
    logic access;
    logic wr_access;

    // Per-register write strobes
    logic wr_ctrl;
    logic wr_test;

    // No wait states
    assign pready = 1'b1;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    assign wr_ctrl = wr_access && (paddr == `HC_REG_CTRL);
    assign wr_test = wr_access && (paddr == `HC_REG_TEST);

    // CTRL register, only client_en lives here
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr.client_en <= 1'b0;
        end
        else if (wr_ctrl)
        begin
            csr.client_en <= pwdata[0];
        end
    end

    // TEST register
    // A write becomes a request held for one cycle only
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr.test_req <= '0;
        end
        else if (wr_test)
        begin
            csr.test_req.mode <= t_hc_mode'(pwdata[1:0]);
            // Top count bit sits above the 32-bit bus and is always zero
            csr.test_req.count <= t_hc_count'(pwdata[31:2]);
        end
        else
        begin
            // Count is kept, only the request is dropped
            csr.test_req.mode <= NORMAL;
        end
    end

    // Read mux, valid during the access phase
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (paddr)
                `HC_REG_CTRL:
                begin
                    prdata[0] = csr.client_en;
                end
                `HC_REG_STATUS:
                begin
                    prdata = 32'(dbg);
                end
                default:
                begin
                    // TEST is write only, unmapped offsets read zero
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/hc_line_fifo.sv ====
`timescale 1ns/1ps

`include "hc_settings.svh"

module hc_line_fifo
#(
    parameter int DEPTH = `HC_FIFO_DEPTH
)
(
    input  logic             clk,
    input  logic             reset_n,

    // Write side
    input  logic             wr_en,
    input  hc_pkg::t_hc_line wr_data,
    output logic             full,

    // Read side, first word falls through
    input  logic             rd_en,
    output hc_pkg::t_hc_line rd_data,
    output logic             empty
);

    import hc_pkg::*;

    // Pointer and occupancy widths, pointer at least one bit
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    t_hc_line mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Guarded transfers, a push when full or a pop when empty is ignored
    logic push;
    logic pop;

    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // Head of the queue drives the output directly
    assign rd_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/hc_tester.sv ====
`timescale 1ns/1ps

module hc_tester
(
    input  logic             clk,
    input  logic             reset_n,

    input  hc_pkg::t_hc_csr  csr,

    // Client side of the to-client path
    output hc_pkg::t_hc_line rx_fifo_data,
    output logic             rx_fifo_rdy,
    input  logic             rx_fifo_enable,

    // Client side of the from-client path
    input  hc_pkg::t_hc_line tx_fifo_data,
    output logic             tx_fifo_rdy,
    input  logic             tx_fifo_enable,

    // Receive FIFO head
    input  hc_pkg::t_hc_line rx_data,
    input  logic             rx_rdy,
    output logic             rx_enable,

    // Transmit FIFO tail
    output hc_pkg::t_hc_line tx_data,
    input  logic             tx_rdy,
    output logic             tx_enable,

    output hc_pkg::t_hc_dbg  dbg
);

    import hc_pkg::*;

    t_hc_mode  mode;
    t_hc_count source_count;

    // Test in progress completes this cycle
    logic test_done;

    // Routing, purely combinational
    always_comb
    begin
        test_done = 1'b0;

        // Data paths default to passthrough
        rx_fifo_data = rx_data;
        tx_data      = tx_fifo_data;

        case (mode)
            SINK:
            begin
                // Client locked out in both directions
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Consume only while the end marker could still be sent
                rx_enable = rx_rdy && tx_rdy;
                test_done = rx_enable && rx_data[0];
                // The terminating line itself goes back as the end marker
                tx_data   = rx_data;
                tx_enable = test_done;
            end
            SOURCE:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Incoming host lines are drained and dropped
                rx_enable = rx_rdy;
                // Count in the low word, bit 0 flags the last line
                tx_data       = '0;
                tx_data[31:0] = {source_count, (source_count == t_hc_count'(1))};
                tx_enable     = tx_rdy;
                test_done     = tx_rdy && (source_count == t_hc_count'(1));
            end
            LOOPBACK:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Pop only when the line can be pushed straight back
                rx_enable = rx_rdy && tx_rdy;
                tx_data   = rx_data;      // whole line, not just the low word
                tx_enable = rx_enable;
                test_done = rx_enable && rx_data[0];
            end
            default:
            begin
                // Normal, client talks to the FIFOs
                rx_fifo_rdy = rx_rdy;
                rx_enable   = rx_fifo_enable && rx_rdy;
                tx_fifo_rdy = tx_rdy && csr.client_en;
                tx_enable   = tx_fifo_enable && tx_fifo_rdy;
            end
        endcase
    end

    // Source counter
    // Loads while idle so the first push already sees the requested count
    always_ff @(posedge clk)
    begin
        if (mode != SOURCE)
        begin
            source_count <= csr.test_req.count;
        end
        else if (tx_rdy)
        begin
            source_count <= source_count - 1'b1;
        end
    end

    // Mode register
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mode <= NORMAL;
        end
        else if (csr.test_req.mode != NORMAL)
        begin
            // A new request overrides any running test
            mode <= csr.test_req.mode;
        end
        else if (test_done)
        begin
            mode <= NORMAL;
        end
    end

    // Debug snapshot, one cycle behind the routing
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            dbg <= '0;
        end
        else
        begin
            dbg.rx_rdy    <= rx_rdy;
            dbg.rx_enable <= rx_enable;
            dbg.tx_rdy    <= tx_rdy;
            dbg.tx_enable <= tx_enable;
            dbg.mode      <= mode;
        end
    end

endmodule

// ==== hw/hc_subsystem_top.sv ====
`timescale 1ns/1ps

`include "hc_settings.svh"

module hc_subsystem_top
(
    input  logic             clk,
    input  logic             reset_n,

    // APB
    input  logic [31:0]      paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,

    // Host to device stream
    input  hc_pkg::t_hc_line host_in_data,
    input  logic             host_in_valid,
    output logic             host_in_ready,

    // Device to host stream
    output hc_pkg::t_hc_line host_out_data,
    output logic             host_out_valid,
    input  logic             host_out_ready,

    // Client ports
    output hc_pkg::t_hc_line rx_fifo_data,
    output logic             rx_fifo_rdy,
    input  logic             rx_fifo_enable,
    input  hc_pkg::t_hc_line tx_fifo_data,
    output logic             tx_fifo_rdy,
    input  logic             tx_fifo_enable
);

    import hc_pkg::*;

    t_hc_csr  csr;
    t_hc_dbg  dbg;

    // Receive FIFO read side
    t_hc_line rx_data;
    logic     rx_empty;
    logic     rx_full;
    logic     rx_rdy;
    logic     rx_enable;

    // Transmit FIFO write side
    t_hc_line tx_data;
    logic     tx_empty;
    logic     tx_full;
    logic     tx_rdy;
    logic     tx_enable;

    // FIFO flags become stream handshakes
    assign host_in_ready  = !rx_full;
    assign rx_rdy         = !rx_empty;
    assign tx_rdy         = !tx_full;
    assign host_out_valid = !tx_empty;

    hc_csr_apb hc_csr_apb_i (
        .clk     (clk),
        .reset_n (reset_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .dbg     (dbg),
        .csr     (csr)
    );

    // Host lines toward the client
    hc_line_fifo #(.DEPTH(`HC_FIFO_DEPTH)) rx_fifo_i (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (host_in_valid),
        .wr_data (host_in_data),
        .full    (rx_full),
        .rd_en   (rx_enable),
        .rd_data (rx_data),
        .empty   (rx_empty)
    );

    // Lines toward the host
    hc_line_fifo #(.DEPTH(`HC_FIFO_DEPTH)) tx_fifo_i (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (tx_enable),
        .wr_data (tx_data),
        .full    (tx_full),
        .rd_en   (host_out_ready),
        .rd_data (host_out_data),
        .empty   (tx_empty)
    );

    hc_tester hc_tester_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .csr            (csr),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .tx_data        (tx_data),
        .tx_rdy         (tx_rdy),
        .tx_enable      (tx_enable),
        .dbg            (dbg)
    );

endmodule

// ==== dv/hc_tb.sv ====
`timescale 1ns/1ps

`include "hc_settings.svh"

module hc_tb;

    import hc_pkg::*;

    // Lines moved per test and used to size the watchdog
    localparam int FILL_LINES   = `HC_FIFO_DEPTH;
    localparam int STREAM_LINES = 4;
    localparam int CLIENT_LINES = 6;
    localparam int LOOP_LINES   = 6;
    localparam int POST_LINES   = 2;
    localparam int SINK_LINES   = 6;
    localparam int SOURCE_LINES = 20;
    localparam int TOTAL_BEATS  = FILL_LINES + STREAM_LINES + CLIENT_LINES + LOOP_LINES
                                + POST_LINES + SINK_LINES + SOURCE_LINES;
    // Four cycles per beat plus a margin for reset, register accesses and fixed waits
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 600;

    logic        clk     = 1'b0;
    logic        reset_n = 1'b0;

    // APB
    logic [31:0] paddr   = '0;
    logic        psel    = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite  = 1'b0;
    logic [31:0] pwdata  = '0;
    logic [31:0] prdata;
    logic        pready;

    // Host streams
    t_hc_line    host_in_data   = '0;
    logic        host_in_valid  = 1'b0;
    logic        host_in_ready;
    t_hc_line    host_out_data;
    logic        host_out_valid;
    logic        host_out_ready = 1'b0;

    // Client ports
    t_hc_line    rx_fifo_data;
    logic        rx_fifo_rdy;
    logic        rx_fifo_enable = 1'b0;
    t_hc_line    tx_fifo_data   = '0;
    logic        tx_fifo_rdy;
    logic        tx_fifo_enable = 1'b0;

    // Stimulus control from the main sequence
    string       test_name       = "reset";
    logic        client_drain    = 1'b0;
    logic        client_locked   = 1'b0;
    logic        client_en_model = 1'b0;
    logic        hold_out        = 1'b0;
    logic        gaps_on         = 1'b0;

    // Expected lines in arrival order
    t_hc_line    exp_host_out[$];
    t_hc_line    exp_client[$];

    hc_subsystem_top hc_subsystem_top_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .host_in_data   (host_in_data),
        .host_in_valid  (host_in_valid),
        .host_in_ready  (host_in_ready),
        .host_out_data  (host_out_data),
        .host_out_valid (host_out_valid),
        .host_out_ready (host_out_ready),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable)
    );

    initial
    begin
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
        $display("Test FAILED");
        $fatal(1, "first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected)
        else report_mismatch(what, expected, actual);
    endtask

    function automatic t_hc_line random_line();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $urandom();
        lo = $urandom();
        return {hi, lo};
    endfunction

    // Setup phase then access phase that completes on its closing edge
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        // prdata is valid while the access phase is open
        @(posedge clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Mode field sits in the low bits of the debug word
    task automatic expect_mode(input t_hc_mode mode);
        logic [31:0] rdata;
        apb_read(`HC_REG_STATUS, rdata);
        check_value("STATUS mode", 64'(mode), 64'(rdata[1:0]));
    endtask

    // Whole debug word while the FIFOs are quiet
    task automatic expect_status(input t_hc_dbg exp_dbg);
        logic [31:0] rdata;
        apb_read(`HC_REG_STATUS, rdata);
        check_value("STATUS word", 64'(exp_dbg), 64'(rdata));
    endtask

    // Hold valid until the rx FIFO takes the line
    task automatic send_host_line(input t_hc_line line);
        @(posedge clk);
        host_in_data  <= line;
        host_in_valid <= 1'b1;
        @(posedge clk);
        while (!host_in_ready)
        begin
            @(posedge clk);
        end
        host_in_valid <= 1'b0;
    endtask

    // Enable only rises after rdy was seen high
    task automatic send_client_line(input t_hc_line line);
        @(posedge clk);
        while (!tx_fifo_rdy)
        begin
            @(posedge clk);
        end
        tx_fifo_data   <= line;
        tx_fifo_enable <= 1'b1;
        @(posedge clk);
        tx_fifo_enable <= 1'b0;
    endtask

    task automatic wait_host_out_drained();
        while (exp_host_out.size() != 0)
        begin
            @(posedge clk);
        end
    endtask

    task automatic wait_client_drained();
        while (exp_client.size() != 0)
        begin
            @(posedge clk);
        end
    endtask

    // Client pops every other cycle so enable never outlives rdy
    always @(posedge clk)
    begin
        rx_fifo_enable <= client_drain && rx_fifo_rdy && !rx_fifo_enable;
    end

    // Host side back-pressure as a long hold or as random gaps
    always @(posedge clk)
    begin
        if (hold_out)
        begin
            host_out_ready <= 1'b0;
        end
        else if (gaps_on)
        begin
            host_out_ready <= ($urandom_range(3) != 0);
        end
        else
        begin
            host_out_ready <= 1'b1;
        end
    end

    always @(posedge clk)
    begin : host_out_scoreboard
        t_hc_line exp_line;
        if (reset_n && host_out_valid && host_out_ready)
        begin
            if (exp_host_out.size() == 0)
            begin
                abort_run("a line left on host_out while none was expected");
            end
            else
            begin
                exp_line = exp_host_out.pop_front();
                assert (host_out_data == exp_line)
                else report_mismatch("host_out_data", exp_line, host_out_data);
            end
        end
    end

    always @(posedge clk)
    begin : client_scoreboard
        t_hc_line exp_line;
        if (reset_n && rx_fifo_rdy && rx_fifo_enable)
        begin
            if (exp_client.size() == 0)
            begin
                abort_run("the client popped a line while none was expected");
            end
            else
            begin
                exp_line = exp_client.pop_front();
                assert (rx_fifo_data == exp_line)
                else report_mismatch("rx_fifo_data", exp_line, rx_fifo_data);
            end
        end
    end

    pready_check: assert property (@(posedge clk) pready)
        else report_mismatch("pready", 64'd1, 64'(pready));

    client_en_check: assert property (@(posedge clk) disable iff (!reset_n)
        !client_en_model |-> !tx_fifo_rdy)
        else report_mismatch("tx_fifo_rdy with client_en clear", 64'd0, 64'(tx_fifo_rdy));

    lockout_check: assert property (@(posedge clk) disable iff (!reset_n)
        client_locked |-> (!rx_fifo_rdy && !tx_fifo_rdy))
        else abort_run("a client ready signal rose while a test mode owned the FIFOs");

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("the watchdog expired before all tests finished");
    end

    initial
    begin : main_sequence
        t_hc_line    line;
        logic [31:0] rdata;
        t_hc_dbg     exp_dbg;

        void'($urandom(32'h8ccf));
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_value("host_out_valid after reset", 64'd0, 64'(host_out_valid));
        check_value("tx_fifo_rdy after reset", 64'd0, 64'(tx_fifo_rdy));
        check_value("rx_fifo_rdy after reset", 64'd0, 64'(rx_fifo_rdy));
        check_value("host_in_ready after reset", 64'd1, 64'(host_in_ready));

        test_name = "registers";
        client_en_model = 1'b1;
        apb_write(`HC_REG_CTRL, 32'h1);
        apb_read(`HC_REG_CTRL, rdata);
        check_value("CTRL readback", 64'd1, 64'(rdata));
        apb_read(`HC_REG_TEST, rdata);
        check_value("TEST readback", 64'd0, 64'(rdata));
        // Both FIFOs empty and idle, so only the tx FIFO reports room
        exp_dbg        = '0;
        exp_dbg.tx_rdy = 1'b1;
        exp_dbg.mode   = NORMAL;
        expect_status(exp_dbg);

        // Fill the rx FIFO with no client pops and drain it while streaming
        test_name = "normal";
        for (int i = 0; i < FILL_LINES; i++)
        begin
            line = random_line();
            exp_client.push_back(line);
            send_host_line(line);
        end
        @(posedge clk);
        check_value("host_in_ready with rx FIFO full", 64'd0, 64'(host_in_ready));
        check_value("rx_fifo_rdy with rx FIFO full", 64'd1, 64'(rx_fifo_rdy));
        client_drain <= 1'b1;
        for (int i = 0; i < STREAM_LINES; i++)
        begin
            line = random_line();
            exp_client.push_back(line);
            send_host_line(line);
        end
        wait_client_drained();
        client_drain <= 1'b0;
        gaps_on <= 1'b1;
        for (int i = 0; i < CLIENT_LINES; i++)
        begin
            line = random_line();
            exp_host_out.push_back(line);
            send_client_line(line);
        end
        wait_host_out_drained();

        // Client transmit path gated off
        apb_write(`HC_REG_CTRL, 32'h0);
        @(posedge clk);
        client_en_model = 1'b0;
        apb_read(`HC_REG_CTRL, rdata);
        check_value("CTRL readback", 64'd0, 64'(rdata));
        repeat (10) @(posedge clk);
        client_en_model = 1'b1;
        apb_write(`HC_REG_CTRL, 32'h1);

        test_name = "loopback";
        apb_write(`HC_REG_TEST, {30'd0, LOOPBACK});
        expect_mode(LOOPBACK);
        client_locked = 1'b1;
        for (int i = 0; i < LOOP_LINES - 1; i++)
        begin
            line = random_line();
            line[0] = 1'b0;
            exp_host_out.push_back(line);
            send_host_line(line);
        end
        client_locked = 1'b0;
        line = random_line();
        line[0] = 1'b1;
        exp_host_out.push_back(line);
        send_host_line(line);
        // Lines behind the terminator go to the client again
        for (int i = 0; i < POST_LINES; i++)
        begin
            line = random_line();
            exp_client.push_back(line);
            send_host_line(line);
        end
        wait_host_out_drained();
        // Back in normal mode with the later lines waiting for the client
        exp_dbg        = '0;
        exp_dbg.rx_rdy = 1'b1;
        exp_dbg.tx_rdy = 1'b1;
        exp_dbg.mode   = NORMAL;
        expect_status(exp_dbg);
        client_drain <= 1'b1;
        wait_client_drained();
        client_drain <= 1'b0;

        test_name = "sink";
        gaps_on <= 1'b0;
        apb_write(`HC_REG_TEST, {30'd0, SINK});
        expect_mode(SINK);
        client_locked = 1'b1;
        for (int i = 0; i < SINK_LINES - 1; i++)
        begin
            line = random_line();
            line[0] = 1'b0;
            send_host_line(line);
        end
        client_locked = 1'b0;
        // Only the terminating line comes back
        line = random_line();
        line[0] = 1'b1;
        exp_host_out.push_back(line);
        send_host_line(line);
        wait_host_out_drained();
        expect_mode(NORMAL);
        repeat (8) @(posedge clk);
        check_value("rx_fifo_rdy after sink", 64'd0, 64'(rx_fifo_rdy));

        // Count N down to 1 in bits 31..1 with the last flag in bit 0
        test_name = "source";
        hold_out <= 1'b1;
        for (int c = SOURCE_LINES; c >= 1; c--)
        begin
            line = '0;
            line[31:1] = 31'(c);
            line[0] = (c == 1);
            exp_host_out.push_back(line);
        end
        apb_write(`HC_REG_TEST, {30'(SOURCE_LINES), SOURCE});
        expect_mode(SOURCE);
        client_locked = 1'b1;
        repeat (12) @(posedge clk);
        check_value("host_out_valid while held", 64'd1, 64'(host_out_valid));
        client_locked = 1'b0;
        gaps_on <= 1'b1;
        hold_out <= 1'b0;
        wait_host_out_drained();
        expect_mode(NORMAL);
        apb_read(`HC_REG_TEST, rdata);
        check_value("TEST readback", 64'd0, 64'(rdata));

        $display("Test OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/hc_pkg.sv
hw/hc_csr_apb.sv
hw/hc_line_fifo.sv
hw/hc_tester.sv
hw/hc_subsystem_top.sv
dv/hc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
# The run passes only when the pass message shows up in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module hc_tb -Mdir obj_dir -f filelist.f &&
./obj_dir/Vhc_tb | tee /dev/stderr | grep "^Test OK$" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
